//--- fir_cfg_pkg.sv
`default_nettype none

package fir_cfg_pkg;

    // **********************************************************************
    // filter arithmetic
    // **********************************************************************

    // number of taps in the filter
    localparam int NUM_TAPS = 11;
    // samples, taps and results share one width
    localparam int DATA_W = 32;
    // tap / window index width
    localparam int TAP_IDX_W = $clog2(NUM_TAPS);
    // result buffer ahead of the stream master
    localparam int OUT_FIFO_DEPTH = 3;

    // signed sample word, products and sums wrap to this
    typedef logic signed [DATA_W-1:0] sample_t;

    // one beat on the stream master
    typedef struct packed {
        sample_t data;
        logic    last;
    } stream_beat_t;

endpackage

`default_nettype wire

//--- fir_bus_pkg.sv
`default_nettype none

package fir_bus_pkg;

    // **********************************************************************
    // register port
    // **********************************************************************

    localparam int ADDR_W = 12;
    // write address / write data buffering
    localparam int LITE_FIFO_DEPTH = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [fir_cfg_pkg::DATA_W-1:0] word_t;

    // address map
    // ctrl bits: 0 ap_start, 1 ap_done, 2 ap_idle
    localparam addr_t REG_CTRL = 12'h000;
    localparam addr_t REG_LENGTH = 12'h010;
    // tap k at base + 4k
    localparam addr_t REG_TAP_BASE = 12'h040;

    // any unmapped read
    localparam word_t UNMAPPED_READ = '1;

    // **********************************************************************
    // control structs
    // **********************************************************************

    // tap write toward the coefficient bank
    typedef struct packed {
        logic                                en;
        logic [fir_cfg_pkg::TAP_IDX_W-1:0]   idx;
        fir_cfg_pkg::sample_t                value;
    } coef_wr_t;

    // run control toward window and engine
    typedef struct packed {
        // one cycle, on the accepted start write
        logic  start;
        // start through run end
        logic  running;
        // samples in this run
        word_t length;
    } run_ctrl_t;

endpackage

`default_nettype wire

//--- fir_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fir_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 3
) (
    input  wire logic axis_clk,
    input  wire logic axis_rst_n,
    input  wire logic push,
    input  payload_t  data_in,
    input  wire logic pop,
    output payload_t  data_out,
    output logic      full,
    output logic      empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // pointer step with wrap at DEPTH
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    // push when full / pop when empty dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    // oldest entry
    assign data_out = mem[rd_ptr];

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_pop)
                rd_ptr <= ptr_next(rd_ptr);
            // occupancy, push and pop together leave it
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge axis_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= data_in;
    end

endmodule

`default_nettype wire

//--- fir_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fir_regs (
    input  wire logic                              axis_clk,
    input  wire logic                              axis_rst_n,
    input  wire logic                              awvalid,
    input  fir_bus_pkg::addr_t                     awaddr,
    output logic                                   awready,
    input  wire logic                              wvalid,
    input  fir_bus_pkg::word_t                     wdata,
    output logic                                   wready,
    input  wire logic                              arvalid,
    input  fir_bus_pkg::addr_t                     araddr,
    output logic                                   arready,
    output logic                                   rvalid,
    input  wire logic                              rready,
    output fir_bus_pkg::word_t                     rdata,
    output logic [fir_cfg_pkg::TAP_IDX_W-1:0]      tap_raddr,
    input  fir_cfg_pkg::sample_t                   tap_rdata,
    output fir_bus_pkg::coef_wr_t                  coef_wr,
    output fir_bus_pkg::run_ctrl_t                 run,
    input  wire logic                              run_end
);
    import fir_cfg_pkg::*;
    import fir_bus_pkg::*;

    addr_t aw_head;
    word_t w_head;
    logic  aw_full;
    logic  aw_empty;
    logic  w_full;
    logic  w_empty;
    logic  wr_pop;
    logic  wr_ctrl;
    logic  start_set;
    logic  ar_fire;
    logic  ap_start;
    logic  ap_done;
    logic  ap_idle;
    logic  running;
    word_t length_q;
    word_t rd_word;

    // tap window, word aligned
    function automatic logic is_tap(input addr_t a);
        return (a >= REG_TAP_BASE) && (a < addr_t'(REG_TAP_BASE + 4 * NUM_TAPS))
            && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [TAP_IDX_W-1:0] tap_index(input addr_t a);
        addr_t offset;
        offset = a - REG_TAP_BASE;
        return offset[TAP_IDX_W+1:2];
    endfunction

    // **********************************************************************
    // write channel, address and data buffered apart
    // **********************************************************************
    assign awready = !aw_full;
    assign wready  = !w_full;
    // one register write per cycle once both sides hold a beat
    assign wr_pop  = !aw_empty && !w_empty;

    fir_fifo #(.payload_t(addr_t), .DEPTH(LITE_FIFO_DEPTH)) i_aw_fifo (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .push       (awvalid),
        .data_in    (awaddr),
        .pop        (wr_pop),
        .data_out   (aw_head),
        .full       (aw_full),
        .empty      (aw_empty)
    );

    fir_fifo #(.payload_t(word_t), .DEPTH(LITE_FIFO_DEPTH)) i_w_fifo (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .push       (wvalid),
        .data_in    (wdata),
        .pop        (wr_pop),
        .data_out   (w_head),
        .full       (w_full),
        .empty      (w_empty)
    );

    // decode of the popped write
    assign wr_ctrl   = wr_pop && (aw_head == REG_CTRL);
    // start only taken while idle and no run armed
    assign start_set = wr_ctrl && w_head[0] && ap_idle && !running;

    // taps straight to the bank
    assign coef_wr.en    = wr_pop && is_tap(aw_head);
    assign coef_wr.idx   = tap_index(aw_head);
    assign coef_wr.value = w_head;

    assign run.start   = start_set;
    assign run.running = running;
    assign run.length  = length_q;

    // control / status
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            ap_start <= 1'b0;
            ap_done  <= 1'b0;
            ap_idle  <= 1'b1;
            running  <= 1'b0;
            length_q <= '0;
        end
        else
        begin
            // engine takes the run the cycle after start
            ap_start <= start_set;
            if (run_end)
                ap_idle <= 1'b1;
            else if (ap_start)
                ap_idle <= 1'b0;
            if (start_set)
                running <= 1'b1;
            else if (run_end)
                running <= 1'b0;
            // set beats a same-cycle status read
            if (run_end)
                ap_done <= 1'b1;
            else if (ar_fire && (araddr == REG_CTRL))
                ap_done <= 1'b0;
            if (wr_pop && (aw_head == REG_LENGTH))
                length_q <= w_head;
        end
    end

    // **********************************************************************
    // read channel, one response outstanding
    // **********************************************************************
    assign arready   = !rvalid;
    assign ar_fire   = arvalid && arready;
    // readback through the bank's second port
    assign tap_raddr = tap_index(araddr);

    always_comb
    begin
        if (araddr == REG_CTRL)
            rd_word = {{(DATA_W - 3){1'b0}}, ap_idle, ap_done, ap_start};
        else if (araddr == REG_LENGTH)
            rd_word = length_q;
        else if (is_tap(araddr))
            rd_word = tap_rdata;
        else
            rd_word = UNMAPPED_READ;
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
            rvalid <= 1'b0;
        else if (ar_fire)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    // response word
    always_ff @(posedge axis_clk)
    begin
        if (ar_fire)
            rdata <= rd_word;
    end

endmodule

`default_nettype wire

//--- fir_coef_bank.sv
`timescale 1ns/1ps
`default_nettype none

module fir_coef_bank (
    input  wire logic                          axis_clk,
    input  wire logic                          axis_rst_n,
    input  fir_bus_pkg::coef_wr_t              coef_wr,
    input  wire logic [fir_cfg_pkg::TAP_IDX_W-1:0] mac_idx,
    input  wire logic [fir_cfg_pkg::TAP_IDX_W-1:0] rd_idx,
    output fir_cfg_pkg::sample_t               mac_tap,
    output fir_cfg_pkg::sample_t               rd_tap
);
    import fir_cfg_pkg::*;

    sample_t taps [NUM_TAPS];

    // **********************************************************************
    // tap registers
    // **********************************************************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            for (int k = 0; k < NUM_TAPS; k++)
                taps[k] <= '0;
        end
        else if (coef_wr.en && (coef_wr.idx < TAP_IDX_W'(NUM_TAPS)))
        begin
            taps[coef_wr.idx] <= coef_wr.value;
        end
    end

    // engine port
    // out of range reads as zero
    assign mac_tap = (mac_idx < TAP_IDX_W'(NUM_TAPS)) ? taps[mac_idx] : '0;

    // register readback port
    assign rd_tap = (rd_idx < TAP_IDX_W'(NUM_TAPS)) ? taps[rd_idx] : '0;

endmodule

`default_nettype wire

//--- fir_sample_window.sv
`timescale 1ns/1ps
`default_nettype none

module fir_sample_window (
    input  wire logic                              axis_clk,
    input  wire logic                              axis_rst_n,
    input  fir_bus_pkg::run_ctrl_t                 run,
    input  wire logic                              shift,
    input  fir_cfg_pkg::sample_t                   ss_tdata,
    input  wire logic [fir_cfg_pkg::TAP_IDX_W-1:0] idx,
    output fir_cfg_pkg::sample_t                   sample
);
    import fir_cfg_pkg::*;

    // entry 0 newest, entry k is x[n-k]
    sample_t win [NUM_TAPS];

    // **********************************************************************
    // delay line
    // **********************************************************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            for (int k = 0; k < NUM_TAPS; k++)
                win[k] <= '0;
        end
        else if (run.start)
        begin
            // new run sees zeros before x[0]
            for (int k = 0; k < NUM_TAPS; k++)
                win[k] <= '0;
        end
        else if (shift)
        begin
            win[0] <= ss_tdata;
            // oldest falls off the end
            for (int k = 1; k < NUM_TAPS; k++)
                win[k] <= win[k-1];
        end
    end

    // read for the engine, guard unused index codes
    assign sample = (idx < TAP_IDX_W'(NUM_TAPS)) ? win[idx] : '0;

endmodule

`default_nettype wire

//--- fir_mac.sv
`timescale 1ns/1ps
`default_nettype none

module fir_mac (
    input  wire logic                          axis_clk,
    input  wire logic                          axis_rst_n,
    input  fir_bus_pkg::run_ctrl_t             run,
    input  wire logic                          ss_tvalid,
    output logic                               ss_tready,
    output logic                               shift,
    output logic [fir_cfg_pkg::TAP_IDX_W-1:0]  idx,
    input  fir_cfg_pkg::sample_t               sample,
    input  fir_cfg_pkg::sample_t               tap,
    input  wire logic                          sm_tready,
    output logic                               sm_tvalid,
    output fir_cfg_pkg::sample_t               sm_tdata,
    output logic                               sm_tlast,
    output logic                               run_end
);
    import fir_cfg_pkg::*;
    import fir_bus_pkg::*;

    word_t        remaining;
    logic         busy;
    logic         push_q;
    logic         last_q;
    sample_t      acc;
    stream_beat_t beat_in;
    stream_beat_t beat_out;
    logic         out_full;
    logic         out_empty;
    logic         out_pop;

    // **********************************************************************
    // input acceptance
    // **********************************************************************
    // one sample in flight, a pending push counts as busy
    // so a free slot is still there when the sum lands
    assign ss_tready = run.running && !busy && !push_q && !out_full && (remaining != '0);
    assign shift     = ss_tvalid && ss_tready;

    // **********************************************************************
    // tap sequencer
    // **********************************************************************
    always_ff @(posedge axis_clk or negedge axis_rst_n)
    begin
        if (!axis_rst_n)
        begin
            remaining <= '0;
            busy      <= 1'b0;
            push_q    <= 1'b0;
            idx       <= '0;
        end
        else
        begin
            push_q <= 1'b0;
            if (run.start)
                remaining <= run.length;
            else if (shift)
                remaining <= remaining - 1'b1;
            if (shift)
            begin
                busy <= 1'b1;
                idx  <= '0;
            end
            else if (busy)
            begin
                // final tap, hand the sum over next cycle
                if (idx == TAP_IDX_W'(NUM_TAPS - 1))
                begin
                    busy   <= 1'b0;
                    push_q <= 1'b1;
                end
                else
                    idx <= idx + 1'b1;
            end
        end
    end

    // accumulate h[k]*x[n-k], wraps to DATA_W
    always_ff @(posedge axis_clk)
    begin
        if (shift)
        begin
            acc    <= '0;
            last_q <= (remaining == word_t'(1));
        end
        else if (busy)
            acc <= acc + sample * tap;
    end

    // **********************************************************************
    // output buffer and end of run
    // **********************************************************************
    assign beat_in.data = acc;
    assign beat_in.last = last_q;
    assign out_pop      = sm_tvalid && sm_tready;

    fir_fifo #(.payload_t(stream_beat_t), .DEPTH(OUT_FIFO_DEPTH)) i_out_fifo (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .push       (push_q),
        .data_in    (beat_in),
        .pop        (out_pop),
        .data_out   (beat_out),
        .full       (out_full),
        .empty      (out_empty)
    );

    assign sm_tvalid = !out_empty;
    assign sm_tdata  = beat_out.data;
    assign sm_tlast  = beat_out.last;
    // last beat handed off
    assign run_end   = out_pop && beat_out.last;

endmodule

`default_nettype wire

//--- fir_top.sv
`timescale 1ns/1ps
`default_nettype none

module fir_top (
    input  wire logic                 axis_clk,
    input  wire logic                 axis_rst_n,
    // register port
    input  wire logic                 awvalid,
    input  fir_bus_pkg::addr_t        awaddr,
    output logic                      awready,
    input  wire logic                 wvalid,
    input  fir_bus_pkg::word_t        wdata,
    output logic                      wready,
    input  wire logic                 arvalid,
    input  fir_bus_pkg::addr_t        araddr,
    output logic                      arready,
    output logic                      rvalid,
    input  wire logic                 rready,
    output fir_bus_pkg::word_t        rdata,
    // sample stream in
    input  wire logic                 ss_tvalid,
    input  fir_cfg_pkg::sample_t      ss_tdata,
    output logic                      ss_tready,
    // result stream out
    input  wire logic                 sm_tready,
    output logic                      sm_tvalid,
    output fir_cfg_pkg::sample_t      sm_tdata,
    output logic                      sm_tlast
);
    import fir_cfg_pkg::*;
    import fir_bus_pkg::*;

    coef_wr_t               coef_wr;
    run_ctrl_t              run;
    logic                   run_end;
    logic                   shift;
    logic [TAP_IDX_W-1:0]   mac_idx;
    logic [TAP_IDX_W-1:0]   tap_raddr;
    sample_t                mac_tap;
    sample_t                rd_tap;
    sample_t                win_sample;

    // **********************************************************************
    // control and storage
    // **********************************************************************
    fir_regs i_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .tap_raddr  (tap_raddr),
        .tap_rdata  (rd_tap),
        .coef_wr    (coef_wr),
        .run        (run),
        .run_end    (run_end)
    );

    fir_coef_bank i_coef (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .coef_wr    (coef_wr),
        .mac_idx    (mac_idx),
        .rd_idx     (tap_raddr),
        .mac_tap    (mac_tap),
        .rd_tap     (rd_tap)
    );

    fir_sample_window i_window (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .run        (run),
        .shift      (shift),
        .ss_tdata   (ss_tdata),
        .idx        (mac_idx),
        .sample     (win_sample)
    );

    // engine, same index into window and bank
    fir_mac i_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .run        (run),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .shift      (shift),
        .idx        (mac_idx),
        .sample     (win_sample),
        .tap        (mac_tap),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .run_end    (run_end)
    );

endmodule

`default_nettype wire

//--- tb_fir.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fir;
    import fir_cfg_pkg::*;
    import fir_bus_pkg::*;

    // longest run, runs per test, register ops in the whole sequence
    localparam int MAX_LEN     = 30;
    localparam int RUN_COUNT   = 2;
    localparam int REG_OPS     = 2 + RUN_COUNT * (2 * NUM_TAPS + 5) + 1;
    localparam int CYCLE_LIMIT = RUN_COUNT * MAX_LEN * (NUM_TAPS + 16) + REG_OPS * 16;

    logic    axis_clk;
    logic    axis_rst_n;
    logic    awvalid;
    addr_t   awaddr;
    logic    awready;
    logic    wvalid;
    word_t   wdata;
    logic    wready;
    logic    arvalid;
    addr_t   araddr;
    logic    arready;
    logic    rvalid;
    logic    rready;
    word_t   rdata;
    logic    ss_tvalid;
    sample_t ss_tdata;
    logic    ss_tready;
    logic    sm_tready;
    logic    sm_tvalid;
    sample_t sm_tdata;
    logic    sm_tlast;

    // reference model state
    sample_t     h_model [NUM_TAPS];
    sample_t     x_hist [$];
    sample_t     exp_q [$];
    sample_t     got_q [$];
    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    fir_top i_dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast)
    );

    // 8 ns clock
    initial
    begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // **********************************************************************
    // helpers
    // **********************************************************************
    // galois lfsr, one step per bit taken, bits packed lsb last
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            r = {r[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return r;
    endfunction

    // y[n] = sum h[k] * x[n-k], zeros before x[0]
    function automatic sample_t model_output(input int n);
        logic signed [63:0] prod;
        sample_t            sum;
        sum = '0;
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            if (n - k >= 0)
            begin
                prod = h_model[k] * x_hist[n - k];
                // wrap to data width
                sum = sum + prod[DATA_W-1:0];
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (expected === actual)
        else
        begin
            value_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d wrong values, %0d other", value_errors, other_errors);
    endtask

    // all bus tasks start and end on a falling edge
    task automatic write_reg(input addr_t addr, input word_t data);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        while (!(awready && wready))
            @(negedge axis_clk);
        @(negedge axis_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // fifo pop and register update
        repeat (2) @(negedge axis_clk);
    endtask

    task automatic read_reg(input addr_t addr, output word_t data);
        arvalid = 1'b1;
        araddr  = addr;
        while (!arready)
            @(negedge axis_clk);
        @(negedge axis_clk);
        arvalid = 1'b0;
        rready  = 1'b1;
        while (!rvalid)
            @(negedge axis_clk);
        data = rdata;
        @(negedge axis_clk);
        rready = 1'b0;
    endtask

    // **********************************************************************
    // stream side
    // **********************************************************************
    task automatic send_samples(input int len);
        for (int i = 0; i < len; i++)
        begin
            // random valid gap
            if (rand_bits(2) == '0)
                repeat (1 + rand_bits(2)) @(negedge axis_clk);
            ss_tvalid = 1'b1;
            ss_tdata  = x_hist[i];
            while (!ss_tready)
                @(negedge axis_clk);
            @(negedge axis_clk);
            ss_tvalid = 1'b0;
        end
    endtask

    task automatic collect_outputs(input string name, input int len);
        int got;
        got = 0;
        while (got < len)
        begin
            @(negedge axis_clk);
            // stall about one cycle in four
            sm_tready = (rand_bits(2) != '0);
            if (sm_tvalid && sm_tready)
            begin
                check_value({name, " data"}, exp_q[got], sm_tdata);
                check_value({name, " last"}, word_t'(got == len - 1), word_t'(sm_tlast));
                got_q.push_back(sm_tdata);
                got++;
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    // taps, length, start, stream, status
    task automatic run_filter(input string name, input logic with_restart);
        word_t              rd;
        int                 len;
        logic signed [63:0] p0;
        x_hist.delete();
        exp_q.delete();
        got_q.delete();
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            h_model[k] = rand_bits(32);
            write_reg(REG_TAP_BASE + addr_t'(4 * k), h_model[k]);
        end
        for (int k = 0; k < NUM_TAPS; k++)
        begin
            read_reg(REG_TAP_BASE + addr_t'(4 * k), rd);
            check_value({name, " tap readback"}, h_model[k], rd);
        end
        len = 20 + int'(rand_bits(5) % 11);
        write_reg(REG_LENGTH, word_t'(len));
        read_reg(REG_LENGTH, rd);
        check_value({name, " length readback"}, word_t'(len), rd);
        // samples and expected results up front
        for (int i = 0; i < len; i++)
            x_hist.push_back(rand_bits(32));
        for (int i = 0; i < len; i++)
            exp_q.push_back(model_output(i));
        write_reg(REG_CTRL, 32'h1);
        fork
            send_samples(len);
            collect_outputs(name, len);
            if (with_restart)
            begin
                // start while busy, must be ignored
                repeat (40) @(negedge axis_clk);
                write_reg(REG_CTRL, 32'h1);
            end
        join
        repeat (4) @(negedge axis_clk);
        assert (!sm_tvalid)
        else
        begin
            other_errors++;
            $display("%s: an extra output beat appeared after the final one", name);
        end
        // cleared window, first result is h0 * x0
        p0 = h_model[0] * x_hist[0];
        check_value({name, " first output"}, p0[DATA_W-1:0], got_q[0]);
        read_reg(REG_CTRL, rd);
        check_value({name, " ctrl after run"}, 32'h6, rd);
        read_reg(REG_CTRL, rd);
        check_value({name, " ctrl second read"}, 32'h4, rd);
    endtask

    // **********************************************************************
    // watchdog
    // **********************************************************************
    always @(posedge axis_clk)
    begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
        begin
            other_errors++;
            $display("timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
            print_counts();
            $display("Testbench failed");
            $finish;
        end
    end

    // main sequence
    initial
    begin
        word_t rd;
        axis_rst_n   = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        ss_tvalid    = 1'b0;
        ss_tdata     = '0;
        sm_tready    = 1'b0;
        lfsr_state   = 32'd86;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        repeat (2) @(posedge axis_clk);
        @(negedge axis_clk);
        axis_rst_n = 1'b1;
        @(negedge axis_clk);
        // awready, wready and arready high, rvalid, ss_tready and sm_tvalid low
        check_value("reset handshakes", word_t'(6'b111000),
                    word_t'({awready, wready, arready, rvalid, ss_tready, sm_tvalid}));
        // idle after reset, unmapped reads all ones
        read_reg(REG_CTRL, rd);
        check_value("reset ctrl", 32'h4, rd);
        read_reg(12'h020, rd);
        check_value("unmapped read", UNMAPPED_READ, rd);
        run_filter("run one", 1'b0);
        run_filter("run two", 1'b1);
        print_counts();
        if (value_errors == 0 && other_errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
fir_cfg_pkg.sv
fir_bus_pkg.sv
fir_fifo.sv
fir_regs.sv
fir_coef_bank.sv
fir_sample_window.sv
fir_mac.sv
fir_top.sv
tb_fir.sv
